// File: jfive_tcm_subsys.f
src/jfive_axi_pkg.sv
src/jfive_tcm_pkg.sv
src/jfive_tcm.sv
src/jfive_ctl_axi4l.sv
src/jfive_mem_axi4.sv
src/jfive_tcm_subsys.sv
test/tb_jfive_tcm_subsys.sv

// File: Makefile
SIM      = verilator
TOP      = tb_jfive_tcm_subsys
FILELIST = jfive_tcm_subsys.f
FLAGS    = --binary --timing --assert -Wno-fatal
OBJ_DIR  = obj_dir
PASS_MSG = *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: test/tb_jfive_tcm_subsys.sv
module tb_jfive_tcm_subsys
    import jfive_axi_pkg::*;
    import jfive_tcm_pkg::*;
    ();

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 8;
    // cycle budgets for registers, incr bursts, errors, window and dual port
    localparam int TEST_CYCLES     = 200 + 1200 + 800 + 400 + 600;
    localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES + RESET_CYCLES;

    logic               clk = 1'b0;
    logic               reset;
    axi4_aw_t           s_axi4_aw, s_axi4_ar;
    axi4_w_t            s_axi4_w;
    axi4_r_t            s_axi4_r;
    logic [ID_W-1:0]    s_axi4_bid;
    axi_resp_t          s_axi4_bresp, s_axi4l_bresp, s_axi4l_rresp;
    logic               s_axi4_awvalid, s_axi4_awready, s_axi4_wvalid, s_axi4_wready;
    logic               s_axi4_bvalid, s_axi4_bready, s_axi4_arvalid, s_axi4_arready;
    logic               s_axi4_rvalid, s_axi4_rready;
    axi4l_addr_t        s_axi4l_aw, s_axi4l_ar;
    axi4l_w_t           s_axi4l_w;
    logic [DATA_W-1:0]  s_axi4l_rdata;
    logic               s_axi4l_awvalid, s_axi4l_awready, s_axi4l_wvalid, s_axi4l_wready;
    logic               s_axi4l_bvalid, s_axi4l_bready, s_axi4l_arvalid, s_axi4l_arready;
    logic               s_axi4l_rvalid, s_axi4l_rready, run;

    logic [15:0]    lfsr = 16'd51459;
    logic [31:0]    model [TCM_WORDS];     // expected tcm contents
    logic [31:0]    lite_rdata;
    axi_resp_t      lite_resp;
    int             err_count = 0;
    int             check_count = 0;
    string          current_test = "reset";

    always #(PERIOD / 2) clk = ~clk;

    jfive_tcm_subsys i_jfive_tcm_subsys (.*);

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_next();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], lfsr_next()};
        return v;
    endfunction

    function automatic void model_write(input logic [TCM_AW-1:0] word, input logic [31:0] data,
                                        input logic [3:0] strb);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) model[word][8*b +: 8] = data[8*b +: 8];
        end
    endfunction

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("ERR t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        end
    endtask

    task automatic reg_write(input logic [7:0] offset, input logic [31:0] data);
        @(posedge clk);
        s_axi4l_aw.addr <= ADDR_W'(offset);
        s_axi4l_w       <= '{data: data, strb: 4'hf};
        s_axi4l_awvalid <= 1'b1;
        s_axi4l_wvalid  <= 1'b1;
        do @(negedge clk); while (!s_axi4l_awready);
        compare("s_axi4l_wready", 1, s_axi4l_wready);
        @(posedge clk);
        s_axi4l_awvalid <= 1'b0;
        s_axi4l_wvalid  <= 1'b0;
        s_axi4l_bready  <= 1'b1;
        do @(negedge clk); while (!s_axi4l_bvalid);
        lite_resp = s_axi4l_bresp;
        @(posedge clk);
        s_axi4l_bready <= 1'b0;
    endtask

    task automatic reg_read(input logic [7:0] offset);
        @(posedge clk);
        s_axi4l_ar.addr <= ADDR_W'(offset);
        s_axi4l_arvalid <= 1'b1;
        do @(negedge clk); while (!s_axi4l_arready);
        @(posedge clk);
        s_axi4l_arvalid <= 1'b0;
        s_axi4l_rready  <= 1'b1;
        do @(negedge clk); while (!s_axi4l_rvalid);
        lite_rdata = s_axi4l_rdata;
        lite_resp  = s_axi4l_rresp;
        @(posedge clk);
        s_axi4l_rready <= 1'b0;
    endtask

    // the model follows only an OKAY burst
    task automatic burst_write(input logic [15:0] id, input logic [39:0] addr,
                               input logic [7:0] len, input axi_burst_t burst,
                               input logic full, input axi_resp_t exp_resp);
        logic [TCM_AW-1:0]  word;
        logic [31:0]        data;
        logic [3:0]         strb;
        word = addr[TCM_AW+1:2];
        @(posedge clk);
        s_axi4_aw      <= '{id: id, addr: addr, len: len, size: 3'd2, burst: burst};
        s_axi4_awvalid <= 1'b1;
        do @(negedge clk); while (!s_axi4_awready);
        @(posedge clk);
        s_axi4_awvalid <= 1'b0;
        for (int i = 0; i <= int'(len); i++) begin
            data = rand_bits(32);
            strb = full ? 4'hf : 4'(rand_bits(4));
            s_axi4_w      <= '{data: data, strb: strb, last: i == int'(len)};
            s_axi4_wvalid <= 1'b1;
            do @(negedge clk); while (!s_axi4_wready);
            @(posedge clk);
            if (exp_resp == OKAY) model_write(word, data, strb);
            if (burst == INCR) word++;
        end
        s_axi4_wvalid <= 1'b0;
        s_axi4_bready <= 1'b1;
        do @(negedge clk); while (!s_axi4_bvalid);
        compare("s_axi4_bid", id, s_axi4_bid);
        compare("s_axi4_bresp", exp_resp, s_axi4_bresp);
        @(posedge clk);
        s_axi4_bready <= 1'b0;
    endtask

    task automatic burst_read(input logic [15:0] id, input logic [39:0] addr,
                              input logic [7:0] len, input axi_burst_t burst,
                              input axi_resp_t exp_resp);
        logic [TCM_AW-1:0]  word;
        int                 beat;
        word = addr[TCM_AW+1:2];
        beat = 0;
        @(posedge clk);
        s_axi4_ar      <= '{id: id, addr: addr, len: len, size: 3'd2, burst: burst};
        s_axi4_arvalid <= 1'b1;
        do @(negedge clk); while (!s_axi4_arready);
        @(posedge clk);
        s_axi4_arvalid <= 1'b0;
        s_axi4_rready  <= 1'(rand_bits(1));
        while (beat <= int'(len)) begin
            @(negedge clk);
            if (s_axi4_rvalid && s_axi4_rready) begin
                compare("s_axi4_r.data", exp_resp == OKAY ? model[word] : 32'h0, s_axi4_r.data);
                compare("s_axi4_r.resp", exp_resp, s_axi4_r.resp);
                compare("s_axi4_r.id", id, s_axi4_r.id);
                compare("s_axi4_r.last", beat == int'(len), s_axi4_r.last);
                beat++;
                if (burst == INCR) word++;
            end
            @(posedge clk);
            s_axi4_rready <= beat <= int'(len) ? 1'(rand_bits(1)) : 1'b0;   // random stalls
        end
    endtask

    task automatic check_registers();
        current_test = "registers";
        @(negedge clk);
        compare("s_axi4_awready", 0, s_axi4_awready);
        compare("s_axi4_wready", 0, s_axi4_wready);
        compare("s_axi4_arready", 0, s_axi4_arready);
        compare("s_axi4_bvalid", 0, s_axi4_bvalid);
        compare("s_axi4_rvalid", 0, s_axi4_rvalid);
        compare("s_axi4l_awready", 0, s_axi4l_awready);
        compare("s_axi4l_wready", 0, s_axi4l_wready);
        compare("s_axi4l_arready", 0, s_axi4l_arready);
        compare("s_axi4l_bvalid", 0, s_axi4l_bvalid);
        compare("s_axi4l_rvalid", 0, s_axi4l_rvalid);
        compare("run", 0, run);
        reg_read(REG_WIN_ADDR);
        compare("win_addr", 0, lite_rdata);
        reg_read(REG_ID);
        compare("id", CORE_ID, lite_rdata);
        reg_write(REG_ID, 32'h1234_5678);   // read only
        compare("id write bresp", OKAY, lite_resp);
        reg_read(REG_ID);
        compare("id after write", CORE_ID, lite_rdata);
        reg_write(REG_CTRL, 32'h1);
        @(negedge clk);
        compare("run", 1, run);
        reg_read(REG_CTRL);
        compare("ctrl", 1, lite_rdata);
        reg_write(8'h10, 32'h0);
        compare("bad offset bresp", SLVERR, lite_resp);
        reg_read(8'h10);
        compare("bad offset rresp", SLVERR, lite_resp);
    endtask

    task automatic incr_roundtrip();
        logic [7:0] lens [3];
        current_test = "incr bursts";
        lens = '{8'd0, 8'd3, 8'd15};
        for (int k = 0; k < 3; k++) begin
            burst_write(16'h10, ADDR_W'(256 * (k + 1)), lens[k], INCR, 1'b1, OKAY);
            burst_write(16'h11, ADDR_W'(256 * (k + 1)), lens[k], INCR, 1'b0, OKAY);
            burst_read(16'h12, ADDR_W'(256 * (k + 1)), lens[k], INCR, OKAY);
        end
    endtask

    task automatic burst_errors();
        current_test = "burst errors";
        burst_write(16'h1, 40'h400, 8'd0, INCR, 1'b1, OKAY);
        burst_write(16'hA5C3, 40'h400, 8'd3, FIXED, 1'b0, OKAY);
        burst_read(16'hA5C4, 40'h400, 8'd0, INCR, OKAY);
        burst_write(16'h2, 40'h500, 8'd3, INCR, 1'b1, OKAY);
        burst_write(16'h3, 40'h500, 8'd3, WRAP, 1'b1, SLVERR);
        burst_read(16'h4, 40'h500, 8'd3, WRAP, SLVERR);
        burst_read(16'h5, 40'h500, 8'd3, INCR, OKAY);
        burst_write(16'h6, 40'h0, 8'd1, INCR, 1'b1, OKAY);
        burst_write(16'h7, 40'hFF8, 8'd1, INCR, 1'b1, OKAY);
        burst_write(16'h8, ADDR_W'(TCM_BYTES), 8'd1, INCR, 1'b1, DECERR);  // would alias word 0
        burst_write(16'h9, 40'hFF8, 8'd3, INCR, 1'b1, DECERR);   // last beat past the end
        burst_read(16'hA, ADDR_W'(TCM_BYTES), 8'd1, INCR, DECERR);
        burst_read(16'hB, 40'h0, 8'd1, INCR, OKAY);
        burst_read(16'hC, 40'hFF8, 8'd1, INCR, OKAY);
    endtask

    task automatic window_access();
        logic [31:0] data;
        current_test = "window";
        reg_write(REG_WIN_ADDR, 32'h600);
        for (int i = 0; i < 4; i++) begin
            data = rand_bits(32);
            reg_write(REG_WIN_DATA, data);
            compare("win write bresp", OKAY, lite_resp);
            model_write(TCM_AW'(10'h180 + i), data, 4'hf);
        end
        reg_read(REG_WIN_ADDR);
        compare("win_addr after writes", 32'h610, lite_rdata);
        burst_read(16'h30, 40'h600, 8'd3, INCR, OKAY);
        reg_write(REG_WIN_ADDR, 32'h604);
        for (int i = 1; i < 3; i++) begin
            reg_read(REG_WIN_DATA);
            compare("win read data", model[10'h180 + i], lite_rdata);
        end
        reg_read(REG_WIN_ADDR);
        compare("win_addr after reads", 32'h60C, lite_rdata);
    endtask

    task automatic dual_port_traffic();
        logic [31:0] wdata [6];
        current_test = "dual port";
        for (int i = 0; i < 6; i++) wdata[i] = rand_bits(32);
        fork
            burst_write(16'h40, 40'h700, 8'd15, INCR, 1'b1, OKAY);
            begin
                reg_write(REG_WIN_ADDR, 32'h800);
                for (int i = 0; i < 6; i++) begin
                    reg_write(REG_WIN_DATA, wdata[i]);
                    model_write(TCM_AW'(10'h200 + i), wdata[i], 4'hf);
                end
            end
        join
        burst_read(16'h41, 40'h700, 8'd15, INCR, OKAY);
        burst_read(16'h42, 40'h800, 8'd5, INCR, OKAY);
    endtask

    initial begin
        s_axi4_aw <= '0;
        s_axi4_ar <= '0;
        s_axi4_w <= '0;
        {s_axi4_awvalid, s_axi4_wvalid, s_axi4_bready, s_axi4_arvalid, s_axi4_rready} <= '0;
        s_axi4l_aw <= '0;
        s_axi4l_ar <= '0;
        s_axi4l_w <= '0;
        {s_axi4l_awvalid, s_axi4l_wvalid, s_axi4l_bready} <= '0;
        {s_axi4l_arvalid, s_axi4l_rready} <= '0;
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        check_registers();
        incr_roundtrip();
        burst_errors();
        window_access();
        dual_port_traffic();
        repeat (4) @(posedge clk);
        $display("%0d errors in %0d checks", err_count, check_count);
        if (err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, stuck in test %s", WATCHDOG_CYCLES, current_test);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: src/jfive_tcm_subsys.sv
module jfive_tcm_subsys
    import jfive_axi_pkg::*;
    import jfive_tcm_pkg::*;
    (
        input   var logic               clk,
        input   var logic               reset,

        input   var axi4_aw_t           s_axi4_aw,
        input   var logic               s_axi4_awvalid,
        output  var logic               s_axi4_awready,
        input   var axi4_w_t            s_axi4_w,
        input   var logic               s_axi4_wvalid,
        output  var logic               s_axi4_wready,
        output  var logic [ID_W-1:0]    s_axi4_bid,
        output  var axi_resp_t          s_axi4_bresp,
        output  var logic               s_axi4_bvalid,
        input   var logic               s_axi4_bready,
        input   var axi4_aw_t           s_axi4_ar,
        input   var logic               s_axi4_arvalid,
        output  var logic               s_axi4_arready,
        output  var axi4_r_t            s_axi4_r,
        output  var logic               s_axi4_rvalid,
        input   var logic               s_axi4_rready,

        input   var axi4l_addr_t        s_axi4l_aw,
        input   var logic               s_axi4l_awvalid,
        output  var logic               s_axi4l_awready,
        input   var axi4l_w_t           s_axi4l_w,
        input   var logic               s_axi4l_wvalid,
        output  var logic               s_axi4l_wready,
        output  var axi_resp_t          s_axi4l_bresp,
        output  var logic               s_axi4l_bvalid,
        input   var logic               s_axi4l_bready,
        input   var axi4l_addr_t        s_axi4l_ar,
        input   var logic               s_axi4l_arvalid,
        output  var logic               s_axi4l_arready,
        output  var logic [DATA_W-1:0]  s_axi4l_rdata,
        output  var axi_resp_t          s_axi4l_rresp,
        output  var logic               s_axi4l_rvalid,
        input   var logic               s_axi4l_rready,

        output  var logic               run
    );

    tcm_req_t       axi_req;
    logic           axi_req_valid;
    logic           axi_gnt;
    tcm_req_t       lite_req;
    logic           lite_req_valid;
    logic           lite_gnt;
    logic [31:0]    tcm_rdata;

    jfive_mem_axi4 i_mem (
        .clk, .reset,
        .s_axi4_aw, .s_axi4_awvalid, .s_axi4_awready,
        .s_axi4_w, .s_axi4_wvalid, .s_axi4_wready,
        .s_axi4_bid, .s_axi4_bresp, .s_axi4_bvalid, .s_axi4_bready,
        .s_axi4_ar, .s_axi4_arvalid, .s_axi4_arready,
        .s_axi4_r, .s_axi4_rvalid, .s_axi4_rready,
        .tcm_req       (axi_req),
        .tcm_req_valid (axi_req_valid),
        .tcm_gnt       (axi_gnt),
        .tcm_rdata
    );

    // control registers and the indirect window
    jfive_ctl_axi4l i_ctl (
        .clk, .reset,
        .s_axi4l_aw, .s_axi4l_awvalid, .s_axi4l_awready,
        .s_axi4l_w, .s_axi4l_wvalid, .s_axi4l_wready,
        .s_axi4l_bresp, .s_axi4l_bvalid, .s_axi4l_bready,
        .s_axi4l_ar, .s_axi4l_arvalid, .s_axi4l_arready,
        .s_axi4l_rdata, .s_axi4l_rresp, .s_axi4l_rvalid, .s_axi4l_rready,
        .tcm_req       (lite_req),
        .tcm_req_valid (lite_req_valid),
        .tcm_gnt       (lite_gnt),
        .tcm_rdata,
        .run
    );

    jfive_tcm i_tcm (
        .clk, .reset,
        .axi_req, .axi_req_valid, .axi_gnt,
        .lite_req, .lite_req_valid, .lite_gnt,
        .rdata (tcm_rdata)
    );

endmodule

// File: src/jfive_mem_axi4.sv
module jfive_mem_axi4
    import jfive_axi_pkg::*;
    import jfive_tcm_pkg::*;
    (
        input   var logic               clk,
        input   var logic               reset,

        input   var axi4_aw_t           s_axi4_aw,
        input   var logic               s_axi4_awvalid,
        output  var logic               s_axi4_awready,
        input   var axi4_w_t            s_axi4_w,
        input   var logic               s_axi4_wvalid,
        output  var logic               s_axi4_wready,
        output  var logic [ID_W-1:0]    s_axi4_bid,
        output  var axi_resp_t          s_axi4_bresp,
        output  var logic               s_axi4_bvalid,
        input   var logic               s_axi4_bready,
        input   var axi4_aw_t           s_axi4_ar,
        input   var logic               s_axi4_arvalid,
        output  var logic               s_axi4_arready,
        output  var axi4_r_t            s_axi4_r,
        output  var logic               s_axi4_rvalid,
        input   var logic               s_axi4_rready,

        output  var tcm_req_t           tcm_req,
        output  var logic               tcm_req_valid,
        input   var logic               tcm_gnt,
        input   var logic [31:0]        tcm_rdata
    );

    typedef enum logic [1:0] {W_IDLE, W_DATA, W_RESP} w_state_t;
    typedef enum logic [1:0] {R_IDLE, R_ISSUE, R_BEAT} r_state_t;

    w_state_t           w_state;
    r_state_t           r_state;
    logic               idle;
    logic [TCM_AW-1:0]  w_addr;
    axi_burst_t         w_burst;
    logic               w_err;
    logic               w_fire;
    logic [ID_W-1:0]    r_id;
    logic [TCM_AW-1:0]  r_addr;
    axi_burst_t         r_burst;
    logic [7:0]         r_len;
    logic [7:0]         r_cnt;
    axi_resp_t          r_resp;
    logic               r_err;
    logic               r_first;    // tcm data is live in the first beat cycle
    logic [31:0]        r_data_q;
    logic               r_fire;

    // whole burst is checked up front; the last beat decides the decode error
    function automatic axi_resp_t burst_resp(axi4_aw_t a);
        logic [ADDR_W:0] last_addr;
        last_addr = {1'b0, a.addr};
        if (a.burst == INCR) last_addr = last_addr + {a.len, 2'b00};
        if (a.burst != FIXED && a.burst != INCR) return SLVERR;
        if (last_addr >= TCM_BYTES) return DECERR;
        return OKAY;
    endfunction

    // one burst at a time and aw wins a tie with ar
    assign idle           = w_state == W_IDLE && r_state == R_IDLE;
    assign s_axi4_awready = idle && s_axi4_awvalid;
    assign s_axi4_arready = idle && s_axi4_arvalid && !s_axi4_awvalid;

    assign w_err         = s_axi4_bresp != OKAY;
    assign s_axi4_wready = w_state == W_DATA && (w_err || tcm_gnt);  // error beats are dropped
    assign w_fire        = s_axi4_wvalid && s_axi4_wready;
    assign s_axi4_bvalid = w_state == W_RESP;

    assign r_err         = r_resp != OKAY;
    assign s_axi4_rvalid = r_state == R_BEAT;
    assign r_fire        = s_axi4_rvalid && s_axi4_rready;

    always_comb begin
        s_axi4_r.id   = r_id;
        s_axi4_r.data = r_err ? '0 : (r_first ? tcm_rdata : r_data_q);
        s_axi4_r.resp = r_resp;
        s_axi4_r.last = r_cnt == r_len;
    end

    assign tcm_req.we    = w_state == W_DATA;
    assign tcm_req.addr  = tcm_req.we ? w_addr : r_addr;
    assign tcm_req.wdata = s_axi4_w.data;
    assign tcm_req.strb  = s_axi4_w.strb;
    assign tcm_req_valid = tcm_req.we ? s_axi4_wvalid && !w_err : r_state == R_ISSUE && !r_err;

    always_ff @(posedge clk) begin
        if (reset) begin
            w_state <= W_IDLE;
        end else begin
            case (w_state)
                W_IDLE: begin
                    if (s_axi4_awready) begin
                        s_axi4_bid   <= s_axi4_aw.id;
                        s_axi4_bresp <= burst_resp(s_axi4_aw);
                        w_addr       <= s_axi4_aw.addr[TCM_AW+1:2];
                        w_burst      <= s_axi4_aw.burst;
                        w_state      <= W_DATA;
                    end
                end
                W_DATA: begin
                    if (w_fire) begin
                        if (w_burst == INCR) w_addr <= w_addr + 1'b1;
                        if (s_axi4_w.last) w_state <= W_RESP;
                    end
                end
                W_RESP:  if (s_axi4_bready) w_state <= W_IDLE;
                default: w_state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            r_state <= R_IDLE;
            r_first <= 1'b0;
        end else begin
            case (r_state)
                R_IDLE: begin
                    if (s_axi4_arready) begin
                        r_id    <= s_axi4_ar.id;
                        r_resp  <= burst_resp(s_axi4_ar);
                        r_addr  <= s_axi4_ar.addr[TCM_AW+1:2];
                        r_burst <= s_axi4_ar.burst;
                        r_len   <= s_axi4_ar.len;
                        r_cnt   <= '0;
                        r_state <= R_ISSUE;
                    end
                end
                R_ISSUE: begin
                    if (r_err || tcm_gnt) begin
                        r_first <= 1'b1;
                        r_state <= R_BEAT;
                    end
                end
                R_BEAT: begin
                    r_first <= 1'b0;
                    if (r_first) r_data_q <= tcm_rdata;     // hold through rready stalls
                    if (r_fire) begin
                        if (r_cnt == r_len) begin
                            r_state <= R_IDLE;
                        end else begin
                            r_cnt   <= r_cnt + 1'b1;
                            if (r_burst == INCR) r_addr <= r_addr + 1'b1;
                            r_state <= R_ISSUE;
                        end
                    end
                end
                default: r_state <= R_IDLE;
            endcase
        end
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
        s_axi4_bvalid && !s_axi4_bready |=> s_axi4_bvalid && $stable({s_axi4_bid, s_axi4_bresp}));

    // the live/held data mux must look like one register to the master
    a_r_stable: assert property (@(posedge clk) disable iff (reset)
        s_axi4_rvalid && !s_axi4_rready |=> s_axi4_rvalid && $stable(s_axi4_r));

endmodule

// File: src/jfive_ctl_axi4l.sv
module jfive_ctl_axi4l
    import jfive_axi_pkg::*;
    import jfive_tcm_pkg::*;
    (
        input   var logic               clk,
        input   var logic               reset,

        input   var axi4l_addr_t        s_axi4l_aw,
        input   var logic               s_axi4l_awvalid,
        output  var logic               s_axi4l_awready,
        input   var axi4l_w_t           s_axi4l_w,
        input   var logic               s_axi4l_wvalid,
        output  var logic               s_axi4l_wready,
        output  var axi_resp_t          s_axi4l_bresp,
        output  var logic               s_axi4l_bvalid,
        input   var logic               s_axi4l_bready,
        input   var axi4l_addr_t        s_axi4l_ar,
        input   var logic               s_axi4l_arvalid,
        output  var logic               s_axi4l_arready,
        output  var logic [DATA_W-1:0]  s_axi4l_rdata,
        output  var axi_resp_t          s_axi4l_rresp,
        output  var logic               s_axi4l_rvalid,
        input   var logic               s_axi4l_rready,

        output  var tcm_req_t           tcm_req,
        output  var logic               tcm_req_valid,
        input   var logic               tcm_gnt,
        input   var logic [31:0]        tcm_rdata,

        output  var logic               run
    );

    typedef enum logic [1:0] {IDLE, WIN_WAIT, RESP_WR, RESP_RD} state_t;

    state_t             state;
    logic [TCM_AW-1:0]  win_addr;
    logic               win_we;     // window access is a write
    logic               win_rd_q;   // tcm read granted last cycle
    logic               wr_both;
    logic               wr_win;
    logic               wr_go;

    assign wr_both = s_axi4l_awvalid && s_axi4l_wvalid;
    assign wr_win  = s_axi4l_aw.addr[7:0] == REG_WIN_DATA;
    assign wr_go   = state == IDLE && wr_both && !wr_win;

    // window writes complete the handshake on the tcm grant
    assign s_axi4l_awready = wr_go || (state == WIN_WAIT && win_we && tcm_gnt);
    assign s_axi4l_wready  = s_axi4l_awready;
    assign s_axi4l_arready = state == IDLE && !wr_both && s_axi4l_arvalid;
    assign s_axi4l_bvalid  = state == RESP_WR;
    assign s_axi4l_rvalid  = state == RESP_RD;

    assign tcm_req = '{we: win_we, addr: win_addr, wdata: s_axi4l_w.data, strb: s_axi4l_w.strb};
    assign tcm_req_valid = state == WIN_WAIT && !win_rd_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            run      <= 1'b0;
            win_addr <= '0;
            win_we   <= 1'b0;
            win_rd_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (wr_both) begin
                        if (wr_win) begin
                            win_we <= 1'b1;
                            state  <= WIN_WAIT;
                        end else begin
                            s_axi4l_bresp <= OKAY;
                            state         <= RESP_WR;
                            case (s_axi4l_aw.addr[7:0])
                                REG_ID:       ;     // read only
                                REG_CTRL:     if (s_axi4l_w.strb[0]) run <= s_axi4l_w.data[0];
                                REG_WIN_ADDR: win_addr <= s_axi4l_w.data[TCM_AW+1:2];
                                default:      s_axi4l_bresp <= SLVERR;
                            endcase
                        end
                    end else if (s_axi4l_arvalid) begin
                        s_axi4l_rresp <= OKAY;
                        state         <= RESP_RD;
                        case (s_axi4l_ar.addr[7:0])
                            REG_ID:       s_axi4l_rdata <= CORE_ID;
                            REG_CTRL:     s_axi4l_rdata <= DATA_W'(run);
                            REG_WIN_ADDR: s_axi4l_rdata <= DATA_W'({win_addr, 2'b00});
                            REG_WIN_DATA: begin
                                win_we <= 1'b0;
                                state  <= WIN_WAIT;
                            end
                            default: begin
                                s_axi4l_rdata <= '0;
                                s_axi4l_rresp <= SLVERR;
                            end
                        endcase
                    end
                end
                WIN_WAIT: begin
                    if (win_rd_q) begin
                        s_axi4l_rdata <= tcm_rdata;
                        win_rd_q      <= 1'b0;
                        state         <= RESP_RD;
                    end else if (tcm_gnt) begin
                        win_addr <= win_addr + 1'b1;    // auto increment per access
                        if (win_we) begin
                            s_axi4l_bresp <= OKAY;
                            state         <= RESP_WR;
                        end else begin
                            win_rd_q <= 1'b1;
                        end
                    end
                end
                RESP_WR: if (s_axi4l_bready) state <= IDLE;
                RESP_RD: if (s_axi4l_rready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: src/jfive_tcm.sv
module jfive_tcm
    import jfive_tcm_pkg::*;
    (
        input   var logic           clk,
        input   var logic           reset,

        input   var tcm_req_t       axi_req,
        input   var logic           axi_req_valid,
        output  var logic           axi_gnt,
        input   var tcm_req_t       lite_req,
        input   var logic           lite_req_valid,
        output  var logic           lite_gnt,

        output  var logic [31:0]    rdata
    );

    logic [31:0]    mem [TCM_WORDS];
    tcm_req_t       req;

    // axi4 port always wins
    assign axi_gnt  = axi_req_valid;
    assign lite_gnt = lite_req_valid && !axi_req_valid;
    assign req      = axi_req_valid ? axi_req : lite_req;

    always_ff @(posedge clk) begin
        if (axi_gnt || lite_gnt) begin
            if (req.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (req.strb[b]) mem[req.addr][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end else begin
                rdata <= mem[req.addr];     // valid the cycle after the grant
            end
        end
    end

    // a lite request held off by the axi4 port stays posted for the same word
    a_lite_hold: assert property (@(posedge clk) disable iff (reset)
        lite_req_valid && !lite_gnt |=> lite_req_valid && $stable({lite_req.we, lite_req.addr}));

endmodule

// File: src/jfive_tcm_pkg.sv
package jfive_tcm_pkg;

    localparam int TCM_AW    = 10;
    localparam int TCM_WORDS = 1 << TCM_AW;     // 4 KiB of 32-bit words
    localparam int TCM_BYTES = TCM_WORDS * 4;

    // control register offsets, decoded from the low address byte
    localparam logic [7:0] REG_ID       = 8'h00;
    localparam logic [7:0] REG_CTRL     = 8'h04;
    localparam logic [7:0] REG_WIN_ADDR = 8'h08;
    localparam logic [7:0] REG_WIN_DATA = 8'h0C;

    localparam logic [31:0] CORE_ID = 32'h4A46_3332;   // "JF32"

    typedef struct packed {
        logic               we;
        logic [TCM_AW-1:0]  addr;     // word address
        logic [31:0]        wdata;
        logic [3:0]         strb;
    } tcm_req_t;

endpackage

// File: src/jfive_axi_pkg.sv
package jfive_axi_pkg;

    localparam int ADDR_W = 40;
    localparam int DATA_W = 32;
    localparam int ID_W   = 16;

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } axi_burst_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_t;

    // address channel, used for aw and ar alike
    typedef struct packed {
        logic [ID_W-1:0]    id;
        logic [ADDR_W-1:0]  addr;
        logic [7:0]         len;
        logic [2:0]         size;
        axi_burst_t         burst;
    } axi4_aw_t;

    typedef struct packed {
        logic [DATA_W-1:0]      data;
        logic [DATA_W/8-1:0]    strb;
        logic                   last;
    } axi4_w_t;

    typedef struct packed {
        logic [ID_W-1:0]    id;
        logic [DATA_W-1:0]  data;
        axi_resp_t          resp;
        logic               last;
    } axi4_r_t;

    typedef struct packed {
        logic [ADDR_W-1:0]  addr;
    } axi4l_addr_t;

    typedef struct packed {
        logic [DATA_W-1:0]      data;
        logic [DATA_W/8-1:0]    strb;
    } axi4l_w_t;

endpackage
